//--- rtl/exec_pkg.sv
package exec_pkg;

	// instruction class seen by the execute stage.
	typedef enum logic [3:0] {
		op_lui,
		op_auipc,
		op_jal,
		op_jalr,
		op_branch,
		op_load,
		op_store,
		op_op_imm,
		op_op,
		op_illegal
	} opcode_e;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and
	} alu_op_e;

	// access size as a byte count.
	typedef enum logic [2:0] {
		mw_none = 3'd0,
		mw_byte = 3'd1,
		mw_half = 3'd2,
		mw_word = 3'd4
	} mem_width_e;

	// rv32i major opcodes.
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;

	// branch conditions.
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	// load and store sizes shared by both classes.
	localparam logic [2:0] F3_B  = 3'b000;
	localparam logic [2:0] F3_H  = 3'b001;
	localparam logic [2:0] F3_W  = 3'b010;
	localparam logic [2:0] F3_BU = 3'b100;
	localparam logic [2:0] F3_HU = 3'b101;

endpackage

//--- rtl/instr_decoder.sv
module instr_decoder (
	input  logic [31:0]         i_instruction,
	output exec_pkg::opcode_e   o_opcode,
	output exec_pkg::alu_op_e   o_alu_op,
	output logic                o_use_imm,
	output logic [31:0]         o_imm,
	output logic [4:0]          o_rd_index,
	output logic [2:0]          o_funct3,
	output logic                o_illegal
);
	import exec_pkg::*;

	logic [6:0]  major;
	logic [2:0]  funct3;
	logic        alt;
	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_u;
	logic [31:0] imm_j;
	alu_op_e     arith_op;

	assign major  = i_instruction[6:0];
	assign funct3 = i_instruction[14:12];
	assign alt    = i_instruction[30];

	assign imm_i = {{20{i_instruction[31]}}, i_instruction[31:20]};
	assign imm_s = {{20{i_instruction[31]}}, i_instruction[31:25], i_instruction[11:7]};
	assign imm_b = {{19{i_instruction[31]}}, i_instruction[31], i_instruction[7],
		i_instruction[30:25], i_instruction[11:8], 1'b0};
	assign imm_u = {i_instruction[31:12], 12'b0};
	assign imm_j = {{11{i_instruction[31]}}, i_instruction[31], i_instruction[19:12],
		i_instruction[20], i_instruction[30:21], 1'b0};

	// sub only exists in the register form.
	always_comb begin
		case (funct3)
			3'b000:  arith_op = (major == OPC_OP && alt) ? alu_sub : alu_add;
			3'b001:  arith_op = alu_sll;
			3'b010:  arith_op = alu_slt;
			3'b011:  arith_op = alu_sltu;
			3'b100:  arith_op = alu_xor;
			3'b101:  arith_op = alt ? alu_sra : alu_srl;
			3'b110:  arith_op = alu_or;
			default: arith_op = alu_and;
		endcase
	end

	always_comb begin
		o_opcode   = op_illegal;
		o_alu_op   = alu_add;
		o_use_imm  = 1'b0;
		o_imm      = 32'd0;
		o_rd_index = i_instruction[11:7];
		o_funct3   = funct3;
		o_illegal  = 1'b0;
		case (major)
			OPC_LUI: begin
				o_opcode  = op_lui;
				o_use_imm = 1'b1;
				o_imm     = imm_u;
			end
			OPC_AUIPC: begin
				o_opcode  = op_auipc;
				o_use_imm = 1'b1;
				o_imm     = imm_u;
			end
			OPC_JAL: begin
				o_opcode = op_jal;
				o_imm    = imm_j;
			end
			OPC_JALR: begin
				o_opcode  = op_jalr;
				o_use_imm = 1'b1;
				o_imm     = imm_i;
			end
			OPC_BRANCH: begin
				o_opcode   = op_branch;
				o_imm      = imm_b;
				o_rd_index = 5'd0;
			end
			OPC_LOAD: begin
				o_opcode  = op_load;
				o_use_imm = 1'b1;
				o_imm     = imm_i;
				o_illegal = !(funct3 inside {F3_B, F3_H, F3_W, F3_BU, F3_HU});
			end
			OPC_STORE: begin
				o_opcode   = op_store;
				o_use_imm  = 1'b1;
				o_imm      = imm_s;
				o_rd_index = 5'd0;
				o_illegal  = !(funct3 inside {F3_B, F3_H, F3_W});
			end
			OPC_OP_IMM: begin
				o_opcode  = op_op_imm;
				o_alu_op  = arith_op;
				o_use_imm = 1'b1;
				// shifts take only the shamt field.
				o_imm     = (funct3[1:0] == 2'b01) ? {27'd0, i_instruction[24:20]} : imm_i;
			end
			OPC_OP: begin
				o_alu_op = arith_op;
				if (i_instruction[25]) begin
					o_illegal = 1'b1;
				end else begin
					o_opcode = op_op;
				end
			end
			default: begin
				o_illegal = 1'b1;
			end
		endcase
	end

endmodule

//--- rtl/alu.sv
module alu (
	input  exec_pkg::alu_op_e i_op,
	input  logic [31:0]       i_op1,
	input  logic [31:0]       i_op2,
	output logic [31:0]       o_result
);
	import exec_pkg::*;

	logic [4:0] shamt;
	logic       lt_signed;
	logic       lt_unsigned;

	assign shamt       = i_op2[4:0];
	assign lt_signed   = $signed(i_op1) < $signed(i_op2);
	assign lt_unsigned = i_op1 < i_op2;

	always_comb begin
		case (i_op)
			alu_add: begin
				o_result = i_op1 + i_op2;
			end
			alu_sub: begin
				o_result = i_op1 - i_op2;
			end
			alu_sll: begin
				o_result = i_op1 << shamt;
			end
			alu_slt: begin
				o_result = {31'd0, lt_signed};
			end
			alu_sltu: begin
				o_result = {31'd0, lt_unsigned};
			end
			alu_xor: begin
				o_result = i_op1 ^ i_op2;
			end
			alu_srl: begin
				o_result = i_op1 >> shamt;
			end
			alu_sra: begin
				o_result = $unsigned($signed(i_op1) >>> shamt);
			end
			alu_or: begin
				o_result = i_op1 | i_op2;
			end
			default: begin
				o_result = i_op1 & i_op2;
			end
		endcase
	end

endmodule

//--- rtl/branch_unit.sv
module branch_unit (
	input  exec_pkg::opcode_e i_opcode,
	input  logic [2:0]        i_funct3,
	input  logic [31:0]       i_rs1,
	input  logic [31:0]       i_rs2,
	input  logic [31:0]       i_pc,
	input  logic [31:0]       i_imm,
	output logic              o_taken,
	output logic [31:0]       o_target
);
	import exec_pkg::*;

	logic        cond;
	logic [31:0] jalr_sum;

	always_comb begin
		case (i_funct3)
			F3_BEQ:  cond = i_rs1 == i_rs2;
			F3_BNE:  cond = i_rs1 != i_rs2;
			F3_BLT:  cond = $signed(i_rs1) < $signed(i_rs2);
			F3_BGE:  cond = $signed(i_rs1) >= $signed(i_rs2);
			F3_BLTU: cond = i_rs1 < i_rs2;
			F3_BGEU: cond = i_rs1 >= i_rs2;
			// 010 and 011 are not branch conditions.
			default: cond = 1'b0;
		endcase
	end

	assign jalr_sum = i_rs1 + i_imm;

	always_comb begin
		case (i_opcode)
			op_jal:    o_taken = 1'b1;
			op_jalr:   o_taken = 1'b1;
			op_branch: o_taken = cond;
			default:   o_taken = 1'b0;
		endcase
	end

	// jalr clears the low bit of its target.
	assign o_target = (i_opcode == op_jalr) ? {jalr_sum[31:1], 1'b0} : i_pc + i_imm;

endmodule

//--- rtl/mem_request.sv
module mem_request (
	input  exec_pkg::opcode_e    i_opcode,
	input  logic [2:0]           i_funct3,
	input  logic [31:0]          i_rs1,
	input  logic [31:0]          i_imm,
	output logic                 o_read,
	output logic                 o_write,
	output exec_pkg::mem_width_e o_width,
	output logic                 o_signed,
	output logic [31:0]          o_address
);
	import exec_pkg::*;

	assign o_address = i_rs1 + i_imm;

	always_comb begin
		o_read   = 1'b0;
		o_write  = 1'b0;
		o_width  = mw_none;
		o_signed = 1'b0;
		if (i_opcode == op_load) begin
			o_read = 1'b1;
			case (i_funct3)
				F3_B:    {o_width, o_signed} = {mw_byte, 1'b1};
				F3_H:    {o_width, o_signed} = {mw_half, 1'b1};
				F3_W:    o_width = mw_word;
				F3_BU:   o_width = mw_byte;
				F3_HU:   o_width = mw_half;
				default: o_read = 1'b0;
			endcase
		end else if (i_opcode == op_store) begin
			o_write = 1'b1;
			case (i_funct3)
				F3_B:    o_width = mw_byte;
				F3_H:    o_width = mw_half;
				F3_W:    o_width = mw_word;
				default: o_write = 1'b0;
			endcase
		end
	end

endmodule

//--- rtl/exec_control.sv
module exec_control #(
	parameter int TAG_W = 8
) (
	input  logic                 i_clock,
	input  logic                 i_rst_n,
	input  logic                 i_stall,
	input  logic [TAG_W-1:0]     i_tag,
	input  logic [31:0]          i_pc,
	input  exec_pkg::opcode_e    i_opcode,
	input  logic [31:0]          i_imm,
	input  logic [4:0]           i_rd_index,
	input  logic                 i_illegal,
	input  logic [31:0]          i_alu_result,
	input  logic [31:0]          i_rs2,
	input  logic                 i_taken,
	input  logic [31:0]          i_target,
	input  logic                 i_mem_read,
	input  logic                 i_mem_write,
	input  exec_pkg::mem_width_e i_mem_width,
	input  logic                 i_mem_signed,
	input  logic [31:0]          i_mem_address,
	output logic [TAG_W-1:0]     o_tag,
	output logic [4:0]           o_inst_rd,
	output logic [31:0]          o_rd,
	output logic                 o_branch,
	output logic [31:0]          o_pc_next,
	output logic                 o_mem_read,
	output logic                 o_mem_write,
	output exec_pkg::mem_width_e o_mem_width,
	output logic                 o_mem_signed,
	output logic [31:0]          o_mem_address,
	output logic                 o_illegal
);
	import exec_pkg::*;

	logic        accept;
	logic        redirect;
	logic [31:0] pc_plus4;
	logic [31:0] auipc_sum;
	logic [31:0] rd_next;

	// a new tag with no stall means a new instruction.
	assign accept    = !i_stall && (i_tag != o_tag);
	assign redirect  = i_taken && !i_illegal;
	assign pc_plus4  = i_pc + 32'd4;
	assign auipc_sum = i_pc + i_imm;

	always_comb begin
		case (i_opcode)
			op_lui:             rd_next = i_imm;
			op_auipc:           rd_next = auipc_sum;
			op_jal, op_jalr:    rd_next = pc_plus4;
			op_store:           rd_next = i_rs2;
			op_branch:          rd_next = o_rd;
			op_illegal:         rd_next = o_rd;
			default:            rd_next = i_alu_result;
		endcase
		if (i_illegal) begin
			rd_next = o_rd;
		end
	end

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			o_tag         <= '0;
			o_inst_rd     <= 5'd0;
			o_branch      <= 1'b0;
			o_pc_next     <= 32'd0;
			o_mem_read    <= 1'b0;
			o_mem_write   <= 1'b0;
			o_mem_width   <= mw_none;
			o_mem_address <= 32'd0;
			o_illegal     <= 1'b0;
		end else if (accept) begin
			o_tag         <= i_tag;
			o_inst_rd     <= i_rd_index;
			o_branch      <= redirect;
			o_pc_next     <= redirect ? i_target : pc_plus4;
			o_mem_read    <= i_mem_read && !i_illegal;
			o_mem_write   <= i_mem_write && !i_illegal;
			o_mem_width   <= i_illegal ? mw_none : i_mem_width;
			o_mem_address <= i_mem_address;
			o_illegal     <= i_illegal;
		end
	end

	always_ff @(posedge i_clock) begin
		if (accept) begin
			o_rd         <= rd_next;
			o_mem_signed <= i_mem_signed && !i_illegal;
		end
	end

endmodule

//--- rtl/exec_top.sv
module exec_top #(
	parameter int TAG_W = 8
) (
	input  logic                 i_clock,
	input  logic                 i_rst_n,
	input  logic                 i_stall,
	input  logic [TAG_W-1:0]     i_tag,
	input  logic [31:0]          i_pc,
	input  logic [31:0]          i_instruction,
	input  logic [31:0]          i_rs1,
	input  logic [31:0]          i_rs2,
	output logic [TAG_W-1:0]     o_tag,
	output logic [4:0]           o_inst_rd,
	output logic [31:0]          o_rd,
	output logic                 o_branch,
	output logic [31:0]          o_pc_next,
	output logic                 o_mem_read,
	output logic                 o_mem_write,
	output exec_pkg::mem_width_e o_mem_width,
	output logic                 o_mem_signed,
	output logic [31:0]          o_mem_address,
	output logic                 o_illegal
);
	import exec_pkg::*;

	opcode_e     opcode;
	alu_op_e     alu_op;
	mem_width_e  mem_width;
	logic        use_imm;
	logic [31:0] imm;
	logic [4:0]  rd_index;
	logic [2:0]  funct3;
	logic        illegal;
	logic [31:0] alu_result;
	logic        taken;
	logic [31:0] target;
	logic        mem_read;
	logic        mem_write;
	logic        mem_signed;
	logic [31:0] mem_address;

	instr_decoder u_decoder (
		.i_instruction (i_instruction),
		.o_opcode      (opcode),
		.o_alu_op      (alu_op),
		.o_use_imm     (use_imm),
		.o_imm         (imm),
		.o_rd_index    (rd_index),
		.o_funct3      (funct3),
		.o_illegal     (illegal)
	);

	alu u_alu (
		.i_op     (alu_op),
		.i_op1    (i_rs1),
		.i_op2    (use_imm ? imm : i_rs2),
		.o_result (alu_result)
	);

	branch_unit u_branch (
		.i_opcode (opcode),
		.i_funct3 (funct3),
		.i_rs1    (i_rs1),
		.i_rs2    (i_rs2),
		.i_pc     (i_pc),
		.i_imm    (imm),
		.o_taken  (taken),
		.o_target (target)
	);

	mem_request u_mem (
		.i_opcode  (opcode),
		.i_funct3  (funct3),
		.i_rs1     (i_rs1),
		.i_imm     (imm),
		.o_read    (mem_read),
		.o_write   (mem_write),
		.o_width   (mem_width),
		.o_signed  (mem_signed),
		.o_address (mem_address)
	);

	exec_control #(
		.TAG_W (TAG_W)
	) u_control (
		.i_clock       (i_clock),
		.i_rst_n       (i_rst_n),
		.i_stall       (i_stall),
		.i_tag         (i_tag),
		.i_pc          (i_pc),
		.i_opcode      (opcode),
		.i_imm         (imm),
		.i_rd_index    (rd_index),
		.i_illegal     (illegal),
		.i_alu_result  (alu_result),
		.i_rs2         (i_rs2),
		.i_taken       (taken),
		.i_target      (target),
		.i_mem_read    (mem_read),
		.i_mem_write   (mem_write),
		.i_mem_width   (mem_width),
		.i_mem_signed  (mem_signed),
		.i_mem_address (mem_address),
		.o_tag         (o_tag),
		.o_inst_rd     (o_inst_rd),
		.o_rd          (o_rd),
		.o_branch      (o_branch),
		.o_pc_next     (o_pc_next),
		.o_mem_read    (o_mem_read),
		.o_mem_write   (o_mem_write),
		.o_mem_width   (o_mem_width),
		.o_mem_signed  (o_mem_signed),
		.o_mem_address (o_mem_address),
		.o_illegal     (o_illegal)
	);

endmodule

//--- verif/tb_exec.sv
module tb_exec;
	timeunit 1ns;
	timeprecision 100ps;
	import exec_pkg::*;

	localparam int TAG_W = 8;
	localparam int N_ALU = 60;
	localparam int N_CTRL = 60;
	localparam int N_MEM = 60;
	localparam int N_ILL = 12;
	// the hold section adds two accepted instructions.
	localparam int N_TOTAL = N_ALU + N_CTRL + N_MEM + N_ILL + 2;
	localparam int CYCLE_LIMIT = 3 * N_TOTAL + 50;

	typedef struct packed {
		logic [4:0]  inst_rd;
		logic [31:0] rd;
		logic        branch;
		logic [31:0] pc_next;
		logic        mem_read;
		logic        mem_write;
		mem_width_e  mem_width;
		logic        mem_signed;
		logic [31:0] mem_address;
		logic        illegal;
		logic        chk_rd;
		logic        chk_addr;
	} result_t;

	logic             i_clock;
	logic             i_rst_n;
	logic             i_stall;
	logic [TAG_W-1:0] i_tag;
	logic [31:0]      i_pc;
	logic [31:0]      i_instruction;
	logic [31:0]      i_rs1;
	logic [31:0]      i_rs2;
	logic [TAG_W-1:0] o_tag;
	logic [4:0]       o_inst_rd;
	logic [31:0]      o_rd;
	logic             o_branch;
	logic [31:0]      o_pc_next;
	logic             o_mem_read;
	logic             o_mem_write;
	mem_width_e       o_mem_width;
	logic             o_mem_signed;
	logic [31:0]      o_mem_address;
	logic             o_illegal;

	logic [31:0]      lfsr_state = 32'd92;
	logic [TAG_W-1:0] next_tag = '0;
	logic [31:0]      model_rd = '0;
	logic             model_ok = 1'b0;
	logic             checks_on = 1'b0;
	int               cycle_count = 0;
	result_t          exp_q[$];

	exec_top #(
		.TAG_W (TAG_W)
	) u_dut (
		.i_clock       (i_clock),
		.i_rst_n       (i_rst_n),
		.i_stall       (i_stall),
		.i_tag         (i_tag),
		.i_pc          (i_pc),
		.i_instruction (i_instruction),
		.i_rs1         (i_rs1),
		.i_rs2         (i_rs2),
		.o_tag         (o_tag),
		.o_inst_rd     (o_inst_rd),
		.o_rd          (o_rd),
		.o_branch      (o_branch),
		.o_pc_next     (o_pc_next),
		.o_mem_read    (o_mem_read),
		.o_mem_write   (o_mem_write),
		.o_mem_width   (o_mem_width),
		.o_mem_signed  (o_mem_signed),
		.o_mem_address (o_mem_address),
		.o_illegal     (o_illegal)
	);

	initial begin
		i_clock = 1'b0;
		forever begin
			#2 i_clock = ~i_clock;
		end
	end

	// x^32 + x^22 + x^2 + x + 1 stepped once per bit.
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int k = 0; k < n; k++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic logic is_rv32i_major(input logic [6:0] major);
		case (major)
			OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH: return 1'b1;
			OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic [31:0] build_instr(input opcode_e cls);
		logic [4:0]  rd;
		logic [4:0]  rs1f;
		logic [4:0]  rs2f;
		logic [2:0]  f3;
		logic [6:0]  hi7;
		logic [6:0]  major;
		logic [11:0] imm12;
		logic [19:0] imm20;
		rd = rand_bits(5);
		rs1f = rand_bits(5);
		rs2f = rand_bits(5);
		f3 = rand_bits(3);
		hi7 = rand_bits(7);
		imm12 = rand_bits(12);
		imm20 = rand_bits(20);
		case (cls)
			op_lui: return {imm20, rd, OPC_LUI};
			op_auipc: return {imm20, rd, OPC_AUIPC};
			op_jal: return {imm20, rd, OPC_JAL};
			op_jalr: return {imm12, rs1f, 3'b000, rd, OPC_JALR};
			op_branch: begin
				// 010 and 011 become bltu and bgeu.
				if (f3[2:1] == 2'b01) begin
					f3[2] = 1'b1;
				end
				return {hi7, rs2f, rs1f, f3, rd, OPC_BRANCH};
			end
			op_load: begin
				if (f3 == 3'b011) begin
					f3 = 3'b010;
				end else if (f3[2:1] == 2'b11) begin
					f3[1] = 1'b0;
				end
				return {imm12, rs1f, f3, rd, OPC_LOAD};
			end
			op_store: begin
				f3[2] = 1'b0;
				if (f3[1:0] == 2'b11) begin
					f3[0] = 1'b0;
				end
				return {hi7, rs2f, rs1f, f3, rd, OPC_STORE};
			end
			op_op_imm: begin
				if (f3 == 3'b001) begin
					return {7'd0, rs2f, rs1f, f3, rd, OPC_OP_IMM};
				end else if (f3 == 3'b101) begin
					return {1'b0, hi7[5], 5'd0, rs2f, rs1f, f3, rd, OPC_OP_IMM};
				end
				return {imm12, rs1f, f3, rd, OPC_OP_IMM};
			end
			op_op: begin
				if (f3 == 3'b000 || f3 == 3'b101) begin
					return {1'b0, hi7[5], 5'd0, rs2f, rs1f, f3, rd, OPC_OP};
				end
				return {7'd0, rs2f, rs1f, f3, rd, OPC_OP};
			end
			default: begin
				// M extension words decode as illegal as well.
				if (hi7[0]) begin
					return {7'd1, rs2f, rs1f, f3, rd, OPC_OP};
				end
				major = rand_bits(7);
				while (is_rv32i_major(major)) begin
					major = rand_bits(7);
				end
				return {imm20, rd, major};
			end
		endcase
	endfunction

	function automatic logic [31:0] arith(input logic [2:0] f3, input logic alt_sub,
		input logic alt_sra, input logic [31:0] a, input logic [31:0] b);
		logic signed [31:0] sa;
		logic [4:0]         sh;
		sa = a;
		sh = b[4:0];
		case (f3)
			3'b000: return alt_sub ? a - b : a + b;
			3'b001: return a << sh;
			3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b011: return (a < b) ? 32'd1 : 32'd0;
			3'b100: return a ^ b;
			3'b101: begin
				if (alt_sra) begin
					return sa >>> sh;
				end
				return a >> sh;
			end
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic result_t ref_result(input logic [31:0] pc, input logic [31:0] instr,
		input logic [31:0] rs1, input logic [31:0] rs2, input logic [31:0] prev_rd,
		input logic prev_ok);
		result_t     r;
		logic [2:0]  f3;
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] imm_b;
		logic [31:0] imm_u;
		logic [31:0] imm_j;
		logic [31:0] sum;
		logic        taken;
		f3 = instr[14:12];
		imm_i = {{20{instr[31]}}, instr[31:20]};
		imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
		imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
		imm_u = {instr[31:12], 12'd0};
		imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
		r = '0;
		r.inst_rd = instr[11:7];
		r.rd = prev_rd;
		r.chk_rd = prev_ok;
		r.pc_next = pc + 32'd4;
		r.mem_width = mw_none;
		case (instr[6:0])
			OPC_LUI: begin
				r.rd = imm_u;
				r.chk_rd = 1'b1;
			end
			OPC_AUIPC: begin
				r.rd = pc + imm_u;
				r.chk_rd = 1'b1;
			end
			OPC_JAL: begin
				r.rd = pc + 32'd4;
				r.chk_rd = 1'b1;
				r.branch = 1'b1;
				r.pc_next = pc + imm_j;
			end
			OPC_JALR: begin
				sum = rs1 + imm_i;
				r.rd = pc + 32'd4;
				r.chk_rd = 1'b1;
				r.branch = 1'b1;
				r.pc_next = {sum[31:1], 1'b0};
			end
			OPC_BRANCH: begin
				r.inst_rd = 5'd0;
				case (f3)
					3'b000: taken = rs1 == rs2;
					3'b001: taken = rs1 != rs2;
					3'b100: taken = $signed(rs1) < $signed(rs2);
					3'b101: taken = $signed(rs1) >= $signed(rs2);
					3'b110: taken = rs1 < rs2;
					default: taken = rs1 >= rs2;
				endcase
				r.branch = taken;
				if (taken) begin
					r.pc_next = pc + imm_b;
				end
			end
			OPC_LOAD, OPC_STORE: begin
				r.mem_read = instr[6:0] == OPC_LOAD;
				r.mem_write = !r.mem_read;
				r.mem_signed = r.mem_read && !f3[2] && f3[1:0] != 2'b10;
				r.mem_address = rs1 + (r.mem_read ? imm_i : imm_s);
				r.chk_addr = 1'b1;
				case (f3[1:0])
					2'b00: r.mem_width = mw_byte;
					2'b01: r.mem_width = mw_half;
					default: r.mem_width = mw_word;
				endcase
				// loads leave o_rd undefined and stores carry rs2 on it.
				r.rd = rs2;
				r.chk_rd = r.mem_write;
				if (r.mem_write) begin
					r.inst_rd = 5'd0;
				end
			end
			OPC_OP_IMM: begin
				sum = (f3[1:0] == 2'b01) ? {27'd0, instr[24:20]} : imm_i;
				r.rd = arith(f3, 1'b0, instr[30], rs1, sum);
				r.chk_rd = 1'b1;
			end
			OPC_OP: begin
				if (instr[25]) begin
					r.illegal = 1'b1;
				end else begin
					r.rd = arith(f3, instr[30], instr[30], rs1, rs2);
					r.chk_rd = 1'b1;
				end
			end
			default: begin
				r.illegal = 1'b1;
			end
		endcase
		return r;
	endfunction

	function automatic result_t capture();
		result_t r;
		r.inst_rd = o_inst_rd;
		r.rd = o_rd;
		r.branch = o_branch;
		r.pc_next = o_pc_next;
		r.mem_read = o_mem_read;
		r.mem_write = o_mem_write;
		r.mem_width = o_mem_width;
		r.mem_signed = o_mem_signed;
		r.mem_address = o_mem_address;
		r.illegal = o_illegal;
		r.chk_rd = 1'b1;
		r.chk_addr = 1'b1;
		return r;
	endfunction

	task automatic abort_run();
		$display("** FAIL **");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_word(input string name, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want) begin
			$display("ERR %s got 0x%08h expected 0x%08h", name, got, want);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic want);
		if (got !== want) begin
			$display("ERR %s got 0x%0h expected 0x%0h", name, got, want);
			abort_run();
		end
	endtask

	task automatic check_width(input string name, input mem_width_e got,
		input mem_width_e want);
		if (got !== want) begin
			$display("ERR %s got 0x%0h expected 0x%0h", name, got, want);
			abort_run();
		end
	endtask

	task automatic compare_result(input result_t got, input result_t want);
		check_word("o_inst_rd", {27'd0, got.inst_rd}, {27'd0, want.inst_rd});
		if (want.chk_rd) begin
			check_word("o_rd", got.rd, want.rd);
		end
		check_bit("o_branch", got.branch, want.branch);
		check_word("o_pc_next", got.pc_next, want.pc_next);
		check_bit("o_mem_read", got.mem_read, want.mem_read);
		check_bit("o_mem_write", got.mem_write, want.mem_write);
		check_width("o_mem_width", got.mem_width, want.mem_width);
		check_bit("o_mem_signed", got.mem_signed, want.mem_signed);
		if (want.chk_addr) begin
			check_word("o_mem_address", got.mem_address, want.mem_address);
		end
		check_bit("o_illegal", got.illegal, want.illegal);
	endtask

	task automatic present(input opcode_e cls);
		logic [31:0] instr;
		logic [31:0] rs1;
		logic [31:0] rs2;
		logic [31:0] pc;
		result_t     want;
		instr = build_instr(cls);
		rs1 = rand_bits(32);
		rs2 = rand_bits(32);
		pc = rand_bits(30) << 2;
		// equal operands half of the time so beq and bge get taken.
		if (cls == op_branch && rand_bits(1) != 0) begin
			rs2 = rs1;
		end
		next_tag = next_tag + 1'b1;
		if (next_tag == '0) begin
			next_tag = 1;
		end
		want = ref_result(pc, instr, rs1, rs2, model_rd, model_ok);
		model_rd = want.rd;
		model_ok = want.chk_rd;
		exp_q.push_back(want);
		i_tag = next_tag;
		i_instruction = instr;
		i_rs1 = rs1;
		i_rs2 = rs2;
		i_pc = pc;
	endtask

	task automatic wait_done();
		do begin
			@(negedge i_clock);
		end while (o_tag !== i_tag);
	endtask

	task automatic run_one(input opcode_e cls);
		present(cls);
		wait_done();
	endtask

	initial begin
		forever begin
			@(posedge i_clock);
			cycle_count++;
			if (cycle_count >= CYCLE_LIMIT) begin
				$display("timeout: the stage did not finish within %0d cycles", CYCLE_LIMIT);
				abort_run();
			end
		end
	end

	// a tag change pops one expected record and otherwise every output must hold.
	initial begin
		result_t          snap;
		result_t          want;
		logic [TAG_W-1:0] seen_tag;
		wait (checks_on);
		snap = capture();
		seen_tag = o_tag;
		forever begin
			@(negedge i_clock);
			if (o_tag === seen_tag) begin
				compare_result(capture(), snap);
			end else if (exp_q.size() == 0) begin
				$display("o_tag changed while no instruction was pending");
				abort_run();
			end else begin
				want = exp_q.pop_front();
				compare_result(capture(), want);
				seen_tag = o_tag;
			end
			snap = capture();
		end
	end

	initial begin
		logic [TAG_W-1:0] held_tag;
		i_rst_n = 1'b0;
		i_stall = 1'b0;
		i_tag = '0;
		i_pc = '0;
		i_instruction = '0;
		i_rs1 = '0;
		i_rs2 = '0;
		repeat (2) @(negedge i_clock);
		i_rst_n = 1'b1;
		check_word("o_tag", {{(32 - TAG_W){1'b0}}, o_tag}, 32'd0);
		check_bit("o_branch", o_branch, 1'b0);
		check_bit("o_mem_read", o_mem_read, 1'b0);
		check_bit("o_mem_write", o_mem_write, 1'b0);
		check_bit("o_illegal", o_illegal, 1'b0);
		check_width("o_mem_width", o_mem_width, mw_none);
		checks_on = 1'b1;
		for (int n = 0; n < N_ALU; n++) begin
			run_one(rand_bits(1) != 0 ? op_op : op_op_imm);
		end
		for (int n = 0; n < N_CTRL; n++) begin
			case (rand_bits(3))
				3: run_one(op_jal);
				4: run_one(op_jalr);
				5: run_one(op_lui);
				6: run_one(op_auipc);
				default: run_one(op_branch);
			endcase
		end
		for (int n = 0; n < N_MEM; n++) begin
			run_one(rand_bits(1) != 0 ? op_load : op_store);
		end
		// stall high with a new tag waiting.
		held_tag = o_tag;
		i_stall = 1'b1;
		present(op_op);
		repeat (5) @(negedge i_clock);
		check_word("o_tag", {{(32 - TAG_W){1'b0}}, o_tag},
			{{(32 - TAG_W){1'b0}}, held_tag});
		i_stall = 1'b0;
		wait_done();
		// new fields under the tag already taken.
		held_tag = o_tag;
		i_instruction = build_instr(op_store);
		i_rs1 = rand_bits(32);
		i_rs2 = rand_bits(32);
		repeat (5) @(negedge i_clock);
		check_word("o_tag", {{(32 - TAG_W){1'b0}}, o_tag},
			{{(32 - TAG_W){1'b0}}, held_tag});
		run_one(op_lui);
		for (int n = 0; n < N_ILL; n++) begin
			run_one(op_illegal);
		end
		repeat (2) @(negedge i_clock);
		if (exp_q.size() == 0) begin
			$display("** PASS **");
			$finish;
		end else begin
			$display("%0d expected results were never checked", exp_q.size());
			abort_run();
		end
	end

endmodule

//--- sim.f
rtl/exec_pkg.sv
rtl/instr_decoder.sv
rtl/alu.sv
rtl/branch_unit.sv
rtl/mem_request.sv
rtl/exec_control.sv
rtl/exec_top.sv
verif/tb_exec.sv

//--- Bender.yml
package:
  name: exec_stage

sources:
  - rtl/exec_pkg.sv
  - rtl/instr_decoder.sv
  - rtl/alu.sv
  - rtl/branch_unit.sv
  - rtl/mem_request.sv
  - rtl/exec_control.sv
  - rtl/exec_top.sv
  - target: simulation
    files:
      - verif/tb_exec.sv
